/* design/GetSw.sv */
// Push switch debounce
// Periodic sampling, two-sample filter, press edge pulse and long-press level
`timescale 1ns/1ps

module GetSw #(
	parameter int pExtSwNum    = 7,
	parameter int pSampCntMax  = 99999,
	parameter int pLongSampNum = 1000
)(
	input  logic                 iSCLK,
	input  logic                 rst,
	input  logic [pExtSwNum-1:0] iPushSw,
	output logic [pExtSwNum-1:0] oEdgeSw,
	output logic [pExtSwNum-1:0] oLongSw
);

	// Counter widths, at least one bit each
	localparam int lpCntWidth  = $clog2(pSampCntMax + 2);
	localparam int lpLongWidth = $clog2(pLongSampNum + 1);

	//--------------------------------------------------
	// Shared sample tick
	//--------------------------------------------------
	logic [lpCntWidth-1:0] sampCnt;
	logic                  sampTick;

	// One tick per pSampCntMax+1 clocks
	assign sampTick = (sampCnt == lpCntWidth'(pSampCntMax));

	always_ff @(posedge iSCLK)
	begin
		if (rst)
			sampCnt <= '0;
		else if (sampTick)
			sampCnt <= '0;
		else
			sampCnt <= sampCnt + 1'b1;
	end

	//--------------------------------------------------
	// Per-switch filter and state
	//--------------------------------------------------
	logic [pExtSwNum-1:0]   lastSamp;
	logic [pExtSwNum-1:0]   edgeQ;
	GpioPkg::SwState_e      swState [pExtSwNum];
	logic [lpLongWidth-1:0] longCnt [pExtSwNum];

	assign oEdgeSw = edgeQ;

	genvar swX;
	generate
		for (swX = 0; swX < pExtSwNum; swX = swX + 1)
		begin : genSw
			logic bothHigh;
			logic bothLow;

			// Current sample agrees with the previous one
			assign bothHigh = iPushSw[swX] & lastSamp[swX];
			assign bothLow  = ~iPushSw[swX] & ~lastSamp[swX];

			// Long level straight from the state register
			assign oLongSw[swX] = (swState[swX] == GpioPkg::SwLongHeld);

			always_ff @(posedge iSCLK)
			begin
				if (rst)
				begin
					lastSamp[swX] <= 1'b0;
					edgeQ[swX]    <= 1'b0;
					swState[swX]  <= GpioPkg::SwReleased;
					longCnt[swX]  <= '0;
				end
				else
				begin
					// Edge lasts a single clock
					edgeQ[swX] <= 1'b0;
					if (sampTick)
					begin
						lastSamp[swX] <= iPushSw[swX];
						case (swState[swX])
							GpioPkg::SwReleased:
							begin
								if (bothHigh)
								begin
									swState[swX] <= GpioPkg::SwPressed;
									longCnt[swX] <= '0;
									edgeQ[swX]   <= 1'b1;
								end
							end
							GpioPkg::SwPressed:
							begin
								// Count every sample taken while pressed
								if (bothLow)
									swState[swX] <= GpioPkg::SwReleased;
								else if (longCnt[swX] == lpLongWidth'(pLongSampNum - 1))
									swState[swX] <= GpioPkg::SwLongHeld;
								else
									longCnt[swX] <= longCnt[swX] + 1'b1;
							end
							GpioPkg::SwLongHeld:
							begin
								if (bothLow)
									swState[swX] <= GpioPkg::SwReleased;
							end
							default:
								swState[swX] <= GpioPkg::SwReleased;
						endcase
					end
				end
			end

			// Edge pulse never stretches over two clocks
			assert property (@(posedge iSCLK) disable iff (rst)
				oEdgeSw[swX] |=> !oEdgeSw[swX])
				else $error("GetSw sw%0d edge pulse longer than one cycle", swX);

			// From release, no long level before the press edge
			assert property (@(posedge iSCLK) disable iff (rst)
				(swState[swX] == GpioPkg::SwReleased) |-> (!oLongSw[swX] until oEdgeSw[swX]))
				else $error("GetSw sw%0d long press without edge", swX);
		end
	endgenerate

endmodule

/* design/GpioBlock.sv */
// GPIO block top level
// CSR, switch debounce and the output pin register with alternate select
`timescale 1ns/1ps

module GpioBlock #(
	parameter int                   pBlockAdrsWidth = 8,
	parameter [pBlockAdrsWidth-1:0] pAdrsMap        = 'h01,
	parameter int                   pCsrAdrsWidth   = 8,
	parameter int                   pGpioWidth      = 16,
	parameter int                   pExtSwNum       = 7,
	parameter int                   pSampCntMax     = 99999,
	parameter int                   pLongSampNum    = 1000
)(
	input  logic                            iSCLK,
	input  logic                            rst,
	// Slave bus
	input  GpioPkg::UsiSlaveReq_t           usiReq,
	output logic [GpioPkg::UsiBusWidth-1:0] oSUsiRd,
	// GPIO pins
	input  logic [pGpioWidth-1:0]           iGpioIn,
	input  logic [pGpioWidth-1:0]           iGpioAltMode,
	output logic [pGpioWidth-1:0]           oGpio,
	output logic [pGpioWidth-1:0]           oGpioDir,
	// Push switches
	input  logic [pExtSwNum-1:0]            iPushSw,
	output logic [pExtSwNum-1:0]            oEdgeSw,
	output logic [pExtSwNum-1:0]            oLongSw,
	input  logic                            iPllLock
);

	//--------------------------------------------------
	// Register space
	//--------------------------------------------------
	logic [pGpioWidth-1:0] gpioOutCtrl;
	logic [pGpioWidth-1:0] gpioAltSel;

	GpioCsr #(
		.pBlockAdrsWidth (pBlockAdrsWidth),
		.pAdrsMap        (pAdrsMap),
		.pCsrAdrsWidth   (pCsrAdrsWidth),
		.pGpioWidth      (pGpioWidth),
		.pExtSwNum       (pExtSwNum)
	) csr (
		.iSCLK        (iSCLK),
		.rst          (rst),
		.usiReq       (usiReq),
		.oSUsiRd      (oSUsiRd),
		.oGpioOutCtrl (gpioOutCtrl),
		.oGpioDir     (oGpioDir),
		.oGpioAltMode (gpioAltSel),
		.iGpioIn      (iGpioIn),
		.iPushSw      (iPushSw),
		.iEdgeSw      (oEdgeSw),
		.iLongSw      (oLongSw),
		.iPllLock     (iPllLock)
	);

	//--------------------------------------------------
	// Switch debounce
	//--------------------------------------------------
	// Outputs go to the ports and back into the CSR
	GetSw #(
		.pExtSwNum    (pExtSwNum),
		.pSampCntMax  (pSampCntMax),
		.pLongSampNum (pLongSampNum)
	) getSw (
		.iSCLK   (iSCLK),
		.rst     (rst),
		.iPushSw (iPushSw),
		.oEdgeSw (oEdgeSw),
		.oLongSw (oLongSw)
	);

	//--------------------------------------------------
	// Output pins
	//--------------------------------------------------
	// Per-bit pick of alternate function or CPU data
	always_ff @(posedge iSCLK)
	begin
		if (rst)
			oGpio <= '0;
		else
			oGpio <= (gpioAltSel & iGpioAltMode) | (~gpioAltSel & gpioOutCtrl);
	end

endmodule

/* design/GpioCsr.sv */
// GPIO control and status registers
// Window decode, control registers, sticky edge flags and registered read data
`timescale 1ns/1ps
`include "GpioCsrMap.svh"

module GpioCsr #(
	parameter int                   pBlockAdrsWidth = 8,
	parameter [pBlockAdrsWidth-1:0] pAdrsMap        = 'h01,
	parameter int                   pCsrAdrsWidth   = 8,
	parameter int                   pGpioWidth      = 16,
	parameter int                   pExtSwNum       = 7
)(
	input  logic                            iSCLK,
	input  logic                            rst,
	input  GpioPkg::UsiSlaveReq_t           usiReq,
	output logic [GpioPkg::UsiBusWidth-1:0] oSUsiRd,
	output logic [pGpioWidth-1:0]           oGpioOutCtrl,
	output logic [pGpioWidth-1:0]           oGpioDir,
	output logic [pGpioWidth-1:0]           oGpioAltMode,
	input  logic [pGpioWidth-1:0]           iGpioIn,
	input  logic [pExtSwNum-1:0]            iPushSw,
	input  logic [pExtSwNum-1:0]            iEdgeSw,
	input  logic [pExtSwNum-1:0]            iLongSw,
	input  logic                            iPllLock
);

	//--------------------------------------------------
	// Address decode
	//--------------------------------------------------
	logic                      inWindow;
	logic [pCsrAdrsWidth-1:0]  csrAdrs;
	logic                      regHit;
	GpioPkg::GpioReg_e         regIdx;
	logic                      wrEn;

	// Upper address bits select this block
	assign inWindow = (usiReq.adrs[GpioPkg::UsiBusWidth-1 -: pBlockAdrsWidth] == pAdrsMap);
	assign csrAdrs  = usiReq.adrs[pCsrAdrsWidth-1:0];

	// Offset to register index
	always_comb
	begin
		regHit = 1'b1;
		regIdx = GpioPkg::RegOut;
		case (csrAdrs)
			`GpioOfsOut:      regIdx = GpioPkg::RegOut;
			`GpioOfsDir:      regIdx = GpioPkg::RegDir;
			`GpioOfsAlt:      regIdx = GpioPkg::RegAlt;
			`GpioOfsIn:       regIdx = GpioPkg::RegIn;
			`GpioOfsSwStat:   regIdx = GpioPkg::RegSwStat;
			`GpioOfsEdgeFlag: regIdx = GpioPkg::RegEdgeFlag;
			default:          regHit = 1'b0;
		endcase
	end

	// No strobe on this bus, an address in the window is a write
	assign wrEn = inWindow & regHit;

	//--------------------------------------------------
	// Control registers and edge flags
	//--------------------------------------------------
	logic [pGpioWidth-1:0] regOut;
	logic [pGpioWidth-1:0] regDir;
	logic [pGpioWidth-1:0] regAlt;
	logic [pExtSwNum-1:0]  edgeFlag;
	logic [pExtSwNum-1:0]  edgeClr;

	// Write 1 to clear
	assign edgeClr = (wrEn && regIdx == GpioPkg::RegEdgeFlag) ?
		usiReq.wd[pExtSwNum-1:0] : '0;

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			regOut   <= '0;
			regDir   <= '0;
			regAlt   <= '0;
			edgeFlag <= '0;
		end
		else
		begin
			if (wrEn)
			begin
				case (regIdx)
					GpioPkg::RegOut: regOut <= usiReq.wd[pGpioWidth-1:0];
					GpioPkg::RegDir: regDir <= usiReq.wd[pGpioWidth-1:0];
					GpioPkg::RegAlt: regAlt <= usiReq.wd[pGpioWidth-1:0];
					// Read-only and flag registers handled elsewhere
					default: ;
				endcase
			end
			// New edge wins over a clear in the same cycle
			edgeFlag <= (edgeFlag & ~edgeClr) | iEdgeSw;
		end
	end

	assign oGpioOutCtrl = regOut;
	assign oGpioDir     = regDir;
	assign oGpioAltMode = regAlt;

	//--------------------------------------------------
	// Read path
	//--------------------------------------------------
	logic [GpioPkg::UsiBusWidth-1:0] rdNext;

	// Zero outside the window so slave read data can be ORed
	always_comb
	begin
		rdNext = '0;
		if (inWindow && regHit)
		begin
			case (regIdx)
				GpioPkg::RegOut:      rdNext[pGpioWidth-1:0] = regOut;
				GpioPkg::RegDir:      rdNext[pGpioWidth-1:0] = regDir;
				GpioPkg::RegAlt:      rdNext[pGpioWidth-1:0] = regAlt;
				GpioPkg::RegIn:       rdNext[pGpioWidth-1:0] = iGpioIn;
				GpioPkg::RegSwStat:
				begin
					rdNext[`GpioStatPushLsb +: pExtSwNum] = iPushSw;
					rdNext[`GpioStatLongLsb +: pExtSwNum] = iLongSw;
					rdNext[`GpioStatPllBit]               = iPllLock;
				end
				GpioPkg::RegEdgeFlag: rdNext[pExtSwNum-1:0] = edgeFlag;
				default:              rdNext = '0;
			endcase
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge iSCLK)
	begin
		if (rst)
			oSUsiRd <= '0;
		else
			oSUsiRd <= rdNext;
	end

	// Foreign addresses leave the control registers alone
	assert property (@(posedge iSCLK) disable iff (rst)
		!inWindow |=> ($stable(regOut) && $stable(regDir) && $stable(regAlt)))
		else $error("GpioCsr register changed by a write outside the window");

endmodule

/* design/GpioPkg.sv */
// GPIO block shared definitions
// Bus width, slave bus request and the register and switch-state encodings
package GpioPkg;

	//--------------------------------------------------
	// Slave bus
	//--------------------------------------------------
	// Address and data width of the slave bus
	localparam int UsiBusWidth = 32;

	// Request from the bus master
	// Write data in the upper half, address in the lower half
	typedef struct packed
	{
		logic [UsiBusWidth-1:0] wd;
		logic [UsiBusWidth-1:0] adrs;
	} UsiSlaveReq_t;

	//--------------------------------------------------
	// Register space
	//--------------------------------------------------
	// Register index, one per 32-bit word
	typedef enum logic [2:0]
	{
		RegOut      = 3'd0,
		RegDir      = 3'd1,
		RegAlt      = 3'd2,
		RegIn       = 3'd3,
		RegSwStat   = 3'd4,
		RegEdgeFlag = 3'd5
	} GpioReg_e;

	//--------------------------------------------------
	// Push switch debounce
	//--------------------------------------------------
	// Debounced state of one switch
	typedef enum logic [1:0]
	{
		SwReleased = 2'd0,
		SwPressed  = 2'd1,
		SwLongHeld = 2'd2
	} SwState_e;

endpackage

/* include/GpioCsrMap.svh */
// GPIO CSR address map
// Byte offsets of the registers and field positions in the status word
`ifndef GPIO_CSR_MAP_SVH
`define GPIO_CSR_MAP_SVH

//--------------------------------------------------
// Register byte offsets inside the block window
//--------------------------------------------------
// Output data driven when alternate mode is off
`define GpioOfsOut      'h00
// Pin direction, 1 means output
`define GpioOfsDir      'h04
// Per-pin alternate function select
`define GpioOfsAlt      'h08
// Input pin levels, read only
`define GpioOfsIn       'h0C
// Switch and PLL status, read only
`define GpioOfsSwStat   'h10
// Sticky edge flags, write 1 to clear
`define GpioOfsEdgeFlag 'h14

//--------------------------------------------------
// Status word fields
//--------------------------------------------------
// Raw push switch levels from bit 0 up
`define GpioStatPushLsb 0
// Long press levels from bit 8 up
`define GpioStatLongLsb 8
// PLL lock level
`define GpioStatPllBit  31

`endif

/* tb.f */
+incdir+include
design/GpioPkg.sv
design/GetSw.sv
design/GpioCsr.sv
design/GpioBlock.sv
testbench/GpioBlockTb.sv

/* testbench/GpioBlockTb.sv */
// GPIO block testbench
// Bus, pin and switch stimulus, checked by assertions against a register model
`timescale 1ns/1ps
`include "GpioCsrMap.svh"

module GpioBlockTb;

	localparam int          lpPeriod      = 40;
	localparam int          lpGpioWidth   = 16;
	localparam int          lpSwNum       = 7;
	localparam logic [7:0]  lpAdrsMap     = 8'h01;
	localparam int          lpSampCntMax  = 3;
	localparam int          lpLongSampNum = 4;
	localparam int          lpSampPer     = lpSampCntMax + 1;
	localparam int          lpRegLoops    = 8;
	localparam int          lpSwLoops     = 2;
	localparam logic [31:0] lpIdleAdrs    = 32'h0000_0000;
	// Reset, register, alternate, window and switch phases in cycles
	localparam int lpStimCycles = 12 + lpRegLoops * 5 + 16 + 16 +
		lpSwLoops * (12 * lpSampPer + lpSampPer * (3 * lpSampPer + 1));

	logic                  iSCLK;
	logic                  rst;
	GpioPkg::UsiSlaveReq_t usiReq;
	logic [31:0]           oSUsiRd;
	logic [lpGpioWidth-1:0] iGpioIn, iGpioAltMode, oGpio, oGpioDir;
	logic [lpSwNum-1:0]    iPushSw, oEdgeSw, oLongSw;
	logic                  iPllLock;

	GpioBlock #(
		.pBlockAdrsWidth (8),
		.pAdrsMap        (lpAdrsMap),
		.pCsrAdrsWidth   (8),
		.pGpioWidth      (lpGpioWidth),
		.pExtSwNum       (lpSwNum),
		.pSampCntMax     (lpSampCntMax),
		.pLongSampNum    (lpLongSampNum)
	) UUT (
		.iSCLK (iSCLK), .rst (rst), .usiReq (usiReq), .oSUsiRd (oSUsiRd),
		.iGpioIn (iGpioIn), .iGpioAltMode (iGpioAltMode), .oGpio (oGpio),
		.oGpioDir (oGpioDir), .iPushSw (iPushSw), .oEdgeSw (oEdgeSw),
		.oLongSw (oLongSw), .iPllLock (iPllLock)
	);

	always #(lpPeriod / 2) iSCLK = ~iSCLK;

	//--------------------------------------------------
	// Error exits
	//--------------------------------------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic reportValue(input string msg);
		abortRun($sformatf("[FAIL] %0t ns %s", $time, msg));
	endtask

	//--------------------------------------------------
	// Random source
	//--------------------------------------------------
	logic [31:0] lfsrState;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] nextBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++)
		begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hD000_0001) : (lfsrState >> 1);
			val[b] = lfsrState[0];
		end
		return val;
	endfunction

	//--------------------------------------------------
	// Register model
	//--------------------------------------------------
	logic [lpGpioWidth-1:0] mOut, mDir, mAlt, expGpio;
	logic [lpSwNum-1:0]     mEdge, mLong, edgeDue, edgeClr;
	logic [31:0]            expRd;
	int                     cyc = 0;
	int                     edgeCnt [lpSwNum];

	// Status and flag words as the register map defines them
	function automatic logic [31:0] expectedRead(input logic [31:0] adrs);
		logic [31:0] val;
		val = '0;
		if (adrs[31:24] == lpAdrsMap)
		begin
			case (adrs[7:0])
				`GpioOfsOut:      val[lpGpioWidth-1:0] = mOut;
				`GpioOfsDir:      val[lpGpioWidth-1:0] = mDir;
				`GpioOfsAlt:      val[lpGpioWidth-1:0] = mAlt;
				`GpioOfsIn:       val[lpGpioWidth-1:0] = iGpioIn;
				`GpioOfsSwStat:
				begin
					val[`GpioStatPushLsb +: lpSwNum] = iPushSw;
					val[`GpioStatLongLsb +: lpSwNum] = mLong;
					val[`GpioStatPllBit]             = iPllLock;
				end
				`GpioOfsEdgeFlag: val[lpSwNum-1:0] = mEdge;
				default:          val = '0;
			endcase
		end
		return val;
	endfunction

	// Each pin follows the alternate input where selected, else the CPU bit
	function automatic logic [lpGpioWidth-1:0] pinValue(
		input logic [lpGpioWidth-1:0] sel,
		input logic [lpGpioWidth-1:0] alt,
		input logic [lpGpioWidth-1:0] cpu
	);
		logic [lpGpioWidth-1:0] val;
		for (int b = 0; b < lpGpioWidth; b++)
			val[b] = sel[b] ? alt[b] : cpu[b];
		return val;
	endfunction

	assign edgeClr = (usiReq.adrs[31:24] == lpAdrsMap && usiReq.adrs[7:0] == `GpioOfsEdgeFlag) ?
		usiReq.wd[lpSwNum-1:0] : '0;

	// Any in-window cycle is a write, read data one cycle later
	always @(posedge iSCLK)
	begin
		cyc <= cyc + 1;
		if (rst)
		begin
			{mOut, mDir, mAlt, expGpio} <= '0;
			mEdge <= '0;
			expRd <= '0;
		end
		else
		begin
			expGpio <= pinValue(mAlt, iGpioAltMode, mOut);
			expRd   <= expectedRead(usiReq.adrs);
			if (usiReq.adrs[31:24] == lpAdrsMap)
			begin
				case (usiReq.adrs[7:0])
					`GpioOfsOut: mOut <= usiReq.wd[lpGpioWidth-1:0];
					`GpioOfsDir: mDir <= usiReq.wd[lpGpioWidth-1:0];
					`GpioOfsAlt: mAlt <= usiReq.wd[lpGpioWidth-1:0];
					default: ;
				endcase
			end
			// Set wins over clear
			for (int s = 0; s < lpSwNum; s++)
			begin
				if (edgeDue[s])
					mEdge[s] <= 1'b1;
				else if (edgeClr[s])
					mEdge[s] <= 1'b0;
			end
		end
	end

	// Edge pulses seen per switch
	always @(posedge iSCLK)
	begin
		for (int s = 0; s < lpSwNum; s++)
			edgeCnt[s] <= rst ? 0 : edgeCnt[s] + int'(oEdgeSw[s]);
	end

	//--------------------------------------------------
	// Checks
	//--------------------------------------------------
	assert property (@(posedge iSCLK) (cyc > 0 && (rst || $past(rst))) |->
		(oGpio == '0 && oGpioDir == '0 && oEdgeSw == '0 && oLongSw == '0 && oSUsiRd == '0))
		else reportValue("outputs not zero around reset");
	assert property (@(posedge iSCLK) disable iff (rst) oGpioDir == mDir)
		else reportValue($sformatf("oGpioDir %h, expected %h", $sampled(oGpioDir), $sampled(mDir)));
	assert property (@(posedge iSCLK) disable iff (rst) oGpio == expGpio)
		else reportValue($sformatf("oGpio %h, expected %h", $sampled(oGpio), $sampled(expGpio)));
	assert property (@(posedge iSCLK) disable iff (rst) oSUsiRd == expRd)
		else reportValue($sformatf("read data %h, expected %h", $sampled(oSUsiRd), $sampled(expRd)));

	//--------------------------------------------------
	// Stimulus helpers
	//--------------------------------------------------
	task automatic nextCycle(input int n);
		repeat (n) @(posedge iSCLK);
		#5;
	endtask

	function automatic logic [7:0] regOfs(input GpioPkg::GpioReg_e r);
		case (r)
			GpioPkg::RegOut:    return `GpioOfsOut;
			GpioPkg::RegDir:    return `GpioOfsDir;
			GpioPkg::RegAlt:    return `GpioOfsAlt;
			GpioPkg::RegIn:     return `GpioOfsIn;
			GpioPkg::RegSwStat: return `GpioOfsSwStat;
			default:            return `GpioOfsEdgeFlag;
		endcase
	endfunction

	// Write data that leaves a register as it is
	function automatic logic [31:0] keepValue(input GpioPkg::GpioReg_e r);
		case (r)
			GpioPkg::RegOut: return 32'(mOut);
			GpioPkg::RegDir: return 32'(mDir);
			GpioPkg::RegAlt: return 32'(mAlt);
			default:         return '0;
		endcase
	endfunction

	task automatic busCycle(input logic [31:0] adrs, input logic [31:0] wd);
		usiReq.adrs = adrs;
		usiReq.wd   = wd;
		nextCycle(1);
	endtask

	task automatic writeReg(input GpioPkg::GpioReg_e r, input logic [31:0] d);
		busCycle({lpAdrsMap, 16'h0, regOfs(r)}, d);
	endtask

	task automatic readReg(input GpioPkg::GpioReg_e r);
		busCycle({lpAdrsMap, 16'h0, regOfs(r)}, keepValue(r));
	endtask

	task automatic idleBus();
		busCycle(lpIdleAdrs, '0);
	endtask

	// Clean press, long hold, flag clear and release on one switch
	task automatic pressRelease(input int sw);
		int base;
		base = edgeCnt[sw];
		iPushSw[sw] = 1'b1;
		nextCycle(3 * lpSampPer);
		assert (edgeCnt[sw] == base + 1)
			else reportValue($sformatf("sw%0d gave %0d edges on press", sw, edgeCnt[sw] - base));
		edgeDue[sw] = 1'b1;
		nextCycle(1);
		edgeDue[sw] = 1'b0;
		nextCycle(4 * lpSampPer - 1);
		assert (oLongSw[sw])
			else reportValue($sformatf("sw%0d oLongSw low after 7 sample periods", sw));
		mLong[sw] = 1'b1;
		readReg(GpioPkg::RegSwStat);
		readReg(GpioPkg::RegEdgeFlag);
		writeReg(GpioPkg::RegEdgeFlag, 32'(1) << sw);
		readReg(GpioPkg::RegEdgeFlag);
		idleBus();
		iPushSw[sw] = 1'b0;
		nextCycle(3 * lpSampPer);
		assert (!oLongSw[sw] && edgeCnt[sw] == base + 1)
			else reportValue($sformatf("sw%0d long level or edge count wrong after release", sw));
		mLong[sw] = 1'b0;
		readReg(GpioPkg::RegSwStat);
		idleBus();
	endtask

	// Single-cycle glitch, no edge expected
	// Each round is one clock past a whole number of sample periods
	// so the glitch meets every sample phase once
	task automatic glitchCheck(input int sw);
		int base;
		base = edgeCnt[sw];
		for (int p = 0; p < lpSampPer; p++)
		begin
			iPushSw[sw] = 1'b1;
			nextCycle(1);
			iPushSw[sw] = 1'b0;
			nextCycle(3 * lpSampPer);
			assert (edgeCnt[sw] == base)
				else reportValue($sformatf("sw%0d glitch produced an edge", sw));
		end
	endtask

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		rst = 1'b1;
		usiReq = '{wd: '0, adrs: lpIdleAdrs};
		{iGpioIn, iGpioAltMode} = '0;
		{iPushSw, edgeDue, mLong} = '0;
		iPllLock = 1'b0;
		lfsrState = 32'hf90b7ac4;
		repeat (10) @(posedge iSCLK);
		#5;
		rst = 1'b0;
		nextCycle(2);
		// Register write and read back, RegAlt still zero
		for (int i = 0; i < lpRegLoops; i++)
		begin
			writeReg(GpioPkg::RegOut, nextBits(lpGpioWidth));
			writeReg(GpioPkg::RegDir, nextBits(lpGpioWidth));
			readReg(GpioPkg::RegOut);
			readReg(GpioPkg::RegDir);
			idleBus();
		end
		// Alternate select with a moving alternate input
		writeReg(GpioPkg::RegAlt, nextBits(lpGpioWidth));
		readReg(GpioPkg::RegAlt);
		idleBus();
		repeat (12)
		begin
			iGpioAltMode = nextBits(lpGpioWidth);
			nextCycle(1);
		end
		// Read-only registers
		iGpioIn = nextBits(lpGpioWidth);
		readReg(GpioPkg::RegIn);
		iPushSw = nextBits(lpSwNum);
		iPllLock = nextBits(1);
		readReg(GpioPkg::RegSwStat);
		iPushSw = '0;
		idleBus();
		// Wrong window, writes ignored and reads zero
		busCycle({8'h02, 16'h0, regOfs(GpioPkg::RegOut)}, nextBits(32));
		busCycle({8'h02, 16'h0, regOfs(GpioPkg::RegDir)}, nextBits(32));
		busCycle({8'h02, 16'h0, regOfs(GpioPkg::RegAlt)}, nextBits(32));
		readReg(GpioPkg::RegOut);
		readReg(GpioPkg::RegDir);
		readReg(GpioPkg::RegAlt);
		idleBus();
		nextCycle(2);
		// Switches
		for (int i = 0; i < lpSwLoops; i++)
		begin
			pressRelease(int'(nextBits(3)) % lpSwNum);
			glitchCheck(int'(nextBits(3)) % lpSwNum);
		end
		nextCycle(2);
		$display("TESTS PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((lpStimCycles * 2 + 500) * lpPeriod);
		abortRun("Watchdog expired before the test sequence finished");
	end

endmodule
